//--- verilog/core_video_pkg.sv
/*
 * Shared types and constants for the video core.
 * Holds the video mode and sequencer state encodings, the PLL reconfiguration
 * tables, the bridge register map and the frame counter width.
 */

package core_video_pkg;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // requested / applied video refresh mode
  typedef enum logic [1:0] {
    VIDEO_50HZ = 2'd0,
    VIDEO_55HZ = 2'd1,
    VIDEO_57HZ = 2'd2,
    VIDEO_60HZ = 2'd3
  } video_timing_t;

  // reconfiguration sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE   = 2'd0,
    SEQ_SETTLE = 2'd1,
    SEQ_WRITE  = 2'd2,
    SEQ_RELOCK = 2'd3
  } seq_state_t;

  ////////////////////////////////////////
  // pll management
  ////////////////////////////////////////

  // address/data pairs per table
  localparam int PLL_PARAM_COUNT = 9;
  // management port address width
  localparam int PLL_CFG_ADDR_W = 6;
  // pause before the first table write
  localparam int SETTLE_CYCLES = 255;

  // tables alternate address then data
  // order: waitrequest mode, M, N, four C counters, bandwidth, start
  localparam logic [31:0] pll_table_55 [0:2*PLL_PARAM_COUNT-1] = '{
    32'h0, 32'h0,
    32'h4, 32'h4040,
    32'h3, 32'h20605,
    32'h5, 32'h20504,
    32'h5, 32'h60E0D,
    32'h5, 32'h83636,
    32'h5, 32'hC3636,
    32'h8, 32'h3,
    32'h2, 32'h0
  };

  localparam logic [31:0] pll_table_57 [0:2*PLL_PARAM_COUNT-1] = '{
    32'h0, 32'h0,
    32'h4, 32'h26F6E,
    32'h3, 32'h20605,
    32'h5, 32'h20807,
    32'h5, 32'h61716,
    32'h5, 32'h85A5A,
    32'h5, 32'hC5A5A,
    32'h8, 32'h2,
    32'h2, 32'h0
  };

  localparam logic [31:0] pll_table_60 [0:2*PLL_PARAM_COUNT-1] = '{
    32'h0, 32'h0,
    32'h4, 32'h24746,
    32'h3, 32'h505,
    32'h5, 32'h505,
    32'h5, 32'h40F0F,
    32'h5, 32'h83C3C,
    32'h5, 32'hC3C3C,
    32'h8, 32'h3,
    32'h2, 32'h0
  };

  ////////////////////////////////////////
  // bridge register map
  ////////////////////////////////////////

  localparam logic [31:0] REG_VID_MODE_ADDR = 32'hF300_0000;
  localparam logic [31:0] REG_STATUS_ADDR   = 32'hFA00_0000;
  localparam logic [31:0] REG_FRAME_ADDR    = 32'hFB00_0000;

  // frame counter as seen over the bridge
  localparam int FRAME_COUNT_W = 16;

endpackage

//--- verilog/bridge_regs.sv
/*
 * Host bridge register block.
 * Takes mode writes from the host, decodes reads of the mode, status and
 * frame counter registers and returns them registered, one cycle after
 * bridge_rd. Every access completes in a single cycle.
 */

`timescale 1ns/1ps

module bridge_regs (
  input  logic                                     clk_74a,
  input  logic                                     reset_n,

  // host bridge, synchronous to clk_74a
  input  logic [31:0]                              bridge_addr,
  input  logic                                     bridge_rd,
  input  logic                                     bridge_wr,
  input  logic [31:0]                              bridge_wr_data,
  output logic [31:0]                              bridge_rd_data,

  // live state for the status word
  input  logic                                     pll_locked,
  input  logic                                     reconfig_pause,
  input  core_video_pkg::seq_state_t               seq_state,
  input  core_video_pkg::video_timing_t            applied_mode,
  input  logic [core_video_pkg::FRAME_COUNT_W-1:0] frame_count,

  // mode level toward the sequencer
  output core_video_pkg::video_timing_t            requested_mode
);

  import core_video_pkg::*;

  logic [31:0] status_word;
  logic [31:0] rd_mux;

  ////////////////////////////////////////
  // mode register
  ////////////////////////////////////////

  // power up in the 55hz mode, same as the sequencer
  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      requested_mode <= VIDEO_55HZ;
    end else if (bridge_wr && (bridge_addr == REG_VID_MODE_ADDR)) begin
      // only the low two bits carry the mode
      requested_mode <= video_timing_t'(bridge_wr_data[1:0]);
    end
  end

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////

  // status layout
  // [0] lock, [1] pause, [3:2] seq state, [5:4] applied mode
  assign status_word = {
    26'd0,
    applied_mode,
    seq_state,
    reconfig_pause,
    pll_locked
  };

  // full 32-bit address match, unmapped reads give zero
  always_comb begin
    case (bridge_addr)
      REG_VID_MODE_ADDR: begin
        rd_mux = {30'd0, requested_mode};
      end
      REG_STATUS_ADDR: begin
        rd_mux = status_word;
      end
      REG_FRAME_ADDR: begin
        rd_mux = {{(32 - FRAME_COUNT_W){1'b0}}, frame_count};
      end
      default: begin
        rd_mux = 32'd0;
      end
    endcase
  end

  // read data valid the cycle after bridge_rd
  // held until the next read
  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      bridge_rd_data <= 32'd0;
    end else if (bridge_rd) begin
      bridge_rd_data <= rd_mux;
    end
  end

endmodule

//--- verilog/pll_reconfig_seq.sv
/*
 * PLL reconfiguration sequencer.
 * On a change of the requested mode it pauses the core, waits a settle time,
 * then writes the nine address/data pairs of the mode table to the PLL
 * management port. Progress only happens while locked and not in waitrequest.
 */

`timescale 1ns/1ps

module pll_reconfig_seq (
  input  logic                                      clk_74a,
  input  logic                                      reset_n,

  // mode level from the register block
  input  core_video_pkg::video_timing_t             requested_mode,

  // pll status, driven outside the design
  input  logic                                      pll_locked,
  input  logic                                      cfg_waitrequest,

  // pll management write port
  output logic                                      cfg_write,
  output logic [core_video_pkg::PLL_CFG_ADDR_W-1:0] cfg_address,
  output logic [31:0]                               cfg_data,

  output logic                                      reconfig_pause,
  output core_video_pkg::seq_state_t                seq_state,
  output core_video_pkg::video_timing_t             applied_mode
);

  import core_video_pkg::*;

  localparam int IDX_W    = $clog2(PLL_PARAM_COUNT);
  localparam int SETTLE_W = $clog2(SETTLE_CYCLES);

  logic                advance;
  logic                last_settle;
  logic                last_pair;
  logic                issue_pair;
  logic [SETTLE_W-1:0] settle_cnt;
  logic [IDX_W-1:0]    param_idx;
  logic [31:0]         addr_word;
  logic [31:0]         data_word;

  // pll ready to take a step
  assign advance     = pll_locked & ~cfg_waitrequest;
  assign last_settle = (settle_cnt == SETTLE_W'(SETTLE_CYCLES - 1));
  assign last_pair   = (param_idx == IDX_W'(PLL_PARAM_COUNT - 1));

  // first pair leaves on the final settle cycle
  // so the first write lands 256 cycles after the mode write
  assign issue_pair = advance &
                      (((seq_state == SEQ_SETTLE) & last_settle) |
                       (seq_state == SEQ_WRITE));

  ////////////////////////////////////////
  // table select
  ////////////////////////////////////////

  // 50hz has no table of its own and runs on the 55hz one
  always_comb begin
    case (applied_mode)
      VIDEO_57HZ: begin
        addr_word = pll_table_57[{param_idx, 1'b0}];
        data_word = pll_table_57[{param_idx, 1'b1}];
      end
      VIDEO_60HZ: begin
        addr_word = pll_table_60[{param_idx, 1'b0}];
        data_word = pll_table_60[{param_idx, 1'b1}];
      end
      default: begin
        addr_word = pll_table_55[{param_idx, 1'b0}];
        data_word = pll_table_55[{param_idx, 1'b1}];
      end
    endcase
  end

  ////////////////////////////////////////
  // sequencer fsm
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      seq_state      <= SEQ_IDLE;
      applied_mode   <= VIDEO_55HZ;
      reconfig_pause <= 1'b0;
      cfg_write      <= 1'b0;
      settle_cnt     <= '0;
      param_idx      <= '0;
    end else begin
      // one pulse per issued pair
      cfg_write <= issue_pair;
      // everything else holds on waitrequest or lost lock
      if (advance) begin
        case (seq_state)
          SEQ_IDLE: begin
            if (requested_mode != applied_mode) begin
              applied_mode   <= requested_mode;
              reconfig_pause <= 1'b1;
              settle_cnt     <= '0;
              param_idx      <= '0;
              seq_state      <= SEQ_SETTLE;
            end
          end
          SEQ_SETTLE: begin
            if (last_settle) begin
              // pair 0 goes out on this edge
              param_idx <= param_idx + 1'b1;
              seq_state <= SEQ_WRITE;
            end else begin
              settle_cnt <= settle_cnt + 1'b1;
            end
          end
          SEQ_WRITE: begin
            // start reconfigure is the last pair
            if (last_pair) begin
              seq_state <= SEQ_RELOCK;
            end else begin
              param_idx <= param_idx + 1'b1;
            end
          end
          SEQ_RELOCK: begin
            // lock is back, release the core
            reconfig_pause <= 1'b0;
            seq_state      <= SEQ_IDLE;
          end
          default: begin
            seq_state <= SEQ_IDLE;
          end
        endcase
      end
    end
  end

  // address/data only move with a write pulse
  always_ff @(posedge clk_74a) begin
    if (issue_pair) begin
      cfg_address <= addr_word[PLL_CFG_ADDR_W-1:0];
      cfg_data    <= data_word;
    end
  end

endmodule

//--- verilog/video_timing_gen.sv
/*
 * Video timing generator.
 * Produces a fixed raster with a flat grey active area, one-cycle sync pulses
 * and a frame counter. All outputs are registered. While the PLL is being
 * reconfigured the raster stops where it is and the outputs go quiet.
 */

`timescale 1ns/1ps

module video_timing_gen #(
  parameter int H_TOTAL    = 400,
  parameter int H_ACTIVE   = 320,
  parameter int H_BPORCH   = 10,
  parameter int V_TOTAL    = 512,
  parameter int V_ACTIVE   = 240,
  parameter int V_BPORCH   = 10,
  parameter int HS_POS     = 3,
  parameter int GREY_LEVEL = 60
) (
  input  logic                                     clk_74a,
  input  logic                                     reset_n,

  // core pause from the sequencer
  input  logic                                     reconfig_pause,

  // scaler side
  output logic [23:0]                              video_rgb,
  output logic                                     video_de,
  output logic                                     video_hs,
  output logic                                     video_vs,

  output logic [core_video_pkg::FRAME_COUNT_W-1:0] frame_count
);

  localparam int X_W = $clog2(H_TOTAL);
  localparam int Y_W = $clog2(V_TOTAL);
  // grey level on each colour channel
  localparam logic [7:0] GREY = 8'(GREY_LEVEL);

  logic [X_W-1:0] x_count;
  logic [Y_W-1:0] y_count;
  logic           line_end;
  logic           frame_end;
  logic           frame_start;
  logic           in_h;
  logic           in_v;
  logic           in_active;

  ////////////////////////////////////////
  // raster decode
  ////////////////////////////////////////

  assign line_end    = (x_count == X_W'(H_TOTAL - 1));
  assign frame_end   = (y_count == Y_W'(V_TOTAL - 1));
  assign frame_start = (x_count == '0) && (y_count == '0);

  // active window sits after the back porch on both axes
  assign in_h = (x_count >= X_W'(H_BPORCH)) &&
                (x_count < X_W'(H_BPORCH + H_ACTIVE));
  assign in_v = (y_count >= Y_W'(V_BPORCH)) &&
                (y_count < Y_W'(V_BPORCH + V_ACTIVE));
  assign in_active = in_h && in_v;

  ////////////////////////////////////////
  // counters and outputs
  ////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      x_count     <= '0;
      y_count     <= '0;
      video_vs    <= 1'b0;
      video_hs    <= 1'b0;
      video_de    <= 1'b0;
      video_rgb   <= 24'd0;
      frame_count <= '0;
    end else if (reconfig_pause) begin
      // hold position, the held pixel comes out after the pause
      video_vs  <= 1'b0;
      video_hs  <= 1'b0;
      video_de  <= 1'b0;
      video_rgb <= 24'd0;
    end else begin
      // x wraps every line, y every frame
      if (line_end) begin
        x_count <= '0;
        if (frame_end) begin
          y_count <= '0;
        end else begin
          y_count <= y_count + 1'b1;
        end
      end else begin
        x_count <= x_count + 1'b1;
      end

      // vs on the first pixel of the frame
      video_vs <= frame_start;
      // hs a few clocks into the line, apart from vs
      video_hs <= (x_count == X_W'(HS_POS));
      video_de <= in_active;

      // grey inside the window, black elsewhere
      video_rgb <= in_active ? {GREY, GREY, GREY} : 24'd0;

      if (frame_start) begin
        frame_count <= frame_count + 1'b1;
      end
    end
  end

endmodule

//--- verilog/core_top.sv
/*
 * Core top level.
 * Connects the bridge register block, the PLL reconfiguration sequencer and
 * the video timing generator, and passes the raster settings down.
 */

`timescale 1ns/1ps

module core_top #(
  parameter int H_TOTAL    = 400,
  parameter int H_ACTIVE   = 320,
  parameter int H_BPORCH   = 10,
  parameter int V_TOTAL    = 512,
  parameter int V_ACTIVE   = 240,
  parameter int V_BPORCH   = 10,
  parameter int HS_POS     = 3,
  parameter int GREY_LEVEL = 60
) (
  input  logic                                      clk_74a,
  input  logic                                      reset_n,

  // host bridge
  input  logic [31:0]                               bridge_addr,
  input  logic                                      bridge_rd,
  output logic [31:0]                               bridge_rd_data,
  input  logic                                      bridge_wr,
  input  logic [31:0]                               bridge_wr_data,

  // external pll
  input  logic                                      pll_locked,
  input  logic                                      cfg_waitrequest,
  output logic                                      cfg_write,
  output logic [core_video_pkg::PLL_CFG_ADDR_W-1:0] cfg_address,
  output logic [31:0]                               cfg_data,

  // video out
  output logic [23:0]                               video_rgb,
  output logic                                      video_de,
  output logic                                      video_hs,
  output logic                                      video_vs
);

  import core_video_pkg::*;

  video_timing_t            requested_mode;
  video_timing_t            applied_mode;
  seq_state_t               seq_state;
  logic                     reconfig_pause;
  logic [FRAME_COUNT_W-1:0] frame_count;

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  bridge_regs u_bridge_regs (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .pll_locked     (pll_locked),
    .reconfig_pause (reconfig_pause),
    .seq_state      (seq_state),
    .applied_mode   (applied_mode),
    .frame_count    (frame_count),
    .requested_mode (requested_mode)
  );

  ////////////////////////////////////////
  // pll sequencing
  ////////////////////////////////////////

  pll_reconfig_seq u_pll_reconfig_seq (
    .clk_74a         (clk_74a),
    .reset_n         (reset_n),
    .requested_mode  (requested_mode),
    .pll_locked      (pll_locked),
    .cfg_waitrequest (cfg_waitrequest),
    .cfg_write       (cfg_write),
    .cfg_address     (cfg_address),
    .cfg_data        (cfg_data),
    .reconfig_pause  (reconfig_pause),
    .seq_state       (seq_state),
    .applied_mode    (applied_mode)
  );

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  // pause goes straight to the raster
  video_timing_gen #(
    .H_TOTAL    (H_TOTAL),
    .H_ACTIVE   (H_ACTIVE),
    .H_BPORCH   (H_BPORCH),
    .V_TOTAL    (V_TOTAL),
    .V_ACTIVE   (V_ACTIVE),
    .V_BPORCH   (V_BPORCH),
    .HS_POS     (HS_POS),
    .GREY_LEVEL (GREY_LEVEL)
  ) u_video_timing_gen (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .reconfig_pause (reconfig_pause),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .frame_count    (frame_count)
  );

endmodule

//--- bench/core_top_tb.sv
/*
 * Testbench for core_top.
 * Plays bench/core_golden.txt against the DUT, models the PLL management
 * port and watches the raster and the PLL writes. Run from the project root.
 */

`timescale 1ns/1ps

module core_top_tb;

  ////////////////////////////////////////
  // constants
  ////////////////////////////////////////

  localparam string GOLDEN_FILE  = "bench/core_golden.txt";
  localparam int    RESET_CYCLES = 16;
  // lock stays low this long after start reconfigure
  localparam int    LOCK_DROP    = 6;
  // default raster, 400 x 512 total with 320 x 240 active
  localparam int    FRAME_CYCLES = 400 * 512;
  localparam int    DE_PER_FRAME = 320 * 240;
  localparam int    HS_PER_FRAME = 512;
  localparam logic [23:0] GREY_RGB = {8'd60, 8'd60, 8'd60};
  // watchdog budget per operation
  localparam int    OP_CYCLES       = 16;
  localparam int    RECONFIG_CYCLES = 4000;

  logic        clk_74a;
  logic        reset_n;
  logic [31:0] bridge_addr;
  logic        bridge_rd;
  logic [31:0] bridge_rd_data;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic        pll_locked;
  logic        cfg_waitrequest;
  logic        cfg_write;
  logic [core_video_pkg::PLL_CFG_ADDR_W-1:0] cfg_address;
  logic [31:0] cfg_data;
  logic [23:0] video_rgb;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;

  // golden operations and expected pll pairs
  logic [7:0]  op_q[$];
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];
  logic [31:0] exp_addr_q[$];
  logic [31:0] exp_data_q[$];
  // pll writes seen on the port
  logic [31:0] got_addr_q[$];
  logic [31:0] got_data_q[$];
  int          pair_ptr = 0;

  // pll model state
  logic [15:0] lfsr_state = 16'd30508;
  logic        model_active = 1'b0;
  int          lock_hold = 0;
  logic        wait_bit_a;
  logic        wait_bit_b;
  // pll was locked and not busy on the previous edge
  logic        ready_d = 1'b0;

  // raster monitor state
  int          vs_count = 0;
  int          frames_checked = 0;
  int          frame_cycles = 0;
  int          de_count = 0;
  int          hs_count = 0;
  logic        vs_seen = 1'b0;
  logic        pause_now = 1'b0;
  logic        pause_d = 1'b0;
  logic        pause_in_frame = 1'b0;
  longint      limit_cycles = 0;

  core_top uut (
    .clk_74a         (clk_74a),
    .reset_n         (reset_n),
    .bridge_addr     (bridge_addr),
    .bridge_rd       (bridge_rd),
    .bridge_rd_data  (bridge_rd_data),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .pll_locked      (pll_locked),
    .cfg_waitrequest (cfg_waitrequest),
    .cfg_write       (cfg_write),
    .cfg_address     (cfg_address),
    .cfg_data        (cfg_data),
    .video_rgb       (video_rgb),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs)
  );

  // 4 ns period
  initial clk_74a = 1'b0;
  always #2 clk_74a = ~clk_74a;

  ////////////////////////////////////////
  // reporting
  ////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] expected,
                       input string what);
    if (got !== expected) begin
      fail_run($sformatf("mismatch at %0t: %s, got %h expected %h",
                         $time, what, got, expected));
    end
  endtask

  ////////////////////////////////////////
  // pll model
  ////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic random_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  always @(posedge clk_74a) begin
    model_active = reset_n;
    // start reconfigure is address 2
    if (!reset_n) begin
      lock_hold = 0;
    end else if (cfg_write && (cfg_address == 6'h02)) begin
      lock_hold = LOCK_DROP;
    end else if (lock_hold != 0) begin
      lock_hold = lock_hold - 1;
    end
    #1;
    pll_locked = model_active && (lock_hold == 0);
    if (model_active) begin
      // busy on about one cycle in four
      random_bit(wait_bit_a);
      random_bit(wait_bit_b);
      cfg_waitrequest = wait_bit_a & wait_bit_b;
    end else begin
      cfg_waitrequest = 1'b0;
    end
  end

  ////////////////////////////////////////
  // monitors
  ////////////////////////////////////////

  always @(posedge clk_74a) begin
    if (reset_n) begin
      pause_now = uut.reconfig_pause;
      if (cfg_write) begin
        check(pause_now, 1'b1, "pll write outside the pause window");
        // write pulse comes from the edge before
        check(ready_d, 1'b1, "pll write issued without lock or during waitrequest");
        got_addr_q.push_back(32'(cfg_address));
        got_data_q.push_back(cfg_data);
      end
      if (pause_now || pause_d) begin
        pause_in_frame = 1'b1;
      end
      // video outputs trail the pause by one cycle
      if (pause_now && pause_d) begin
        check({video_vs, video_hs, video_de}, 3'b000, "sync or de while paused");
      end
      if (video_de) begin
        check(video_rgb, GREY_RGB, "rgb inside the active area");
      end else begin
        check(video_rgb, 24'd0, "rgb outside the active area");
      end
      if (video_vs) begin
        vs_count = vs_count + 1;
        // only frames that ran without a pause
        if (vs_seen && !pause_in_frame) begin
          check(frame_cycles, FRAME_CYCLES, "cycles between vs pulses");
          check(de_count, DE_PER_FRAME, "de cycles per frame");
          check(hs_count, HS_PER_FRAME, "hs pulses per frame");
          frames_checked = frames_checked + 1;
        end
        vs_seen        = 1'b1;
        frame_cycles   = 0;
        de_count       = 0;
        hs_count       = 0;
        pause_in_frame = pause_now;
      end
      frame_cycles = frame_cycles + 1;
      de_count     = de_count + int'(video_de);
      hs_count     = hs_count + int'(video_hs);
      pause_d      = pause_now;
      ready_d      = pll_locked && !cfg_waitrequest;
    end
  end

  ////////////////////////////////////////
  // golden file
  ////////////////////////////////////////

  task automatic load_golden();
    int               fd;
    int               code;
    int               k;
    logic [7:0]       op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      w [0:5];
    logic [8*160-1:0] rest;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      fail_run("could not open the golden file bench/core_golden.txt");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", op);
      if (code == 1) begin
        case (op)
          "#": begin
            code = $fgets(rest, fd);
          end
          "W", "R": begin
            code = $fscanf(fd, "%h %h", a, b);
            if (code != 2) fail_run("golden file line is missing a field");
            op_q.push_back(op);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
          end
          "C", "F", "N": begin
            code = $fscanf(fd, "%h", a);
            if (code != 1) fail_run("golden file line is missing a field");
            op_q.push_back(op);
            arg_a_q.push_back(a);
            arg_b_q.push_back(32'd0);
          end
          "P": begin
            code = $fscanf(fd, "%h %h %h %h %h %h", w[0], w[1], w[2], w[3], w[4], w[5]);
            if (code != 6) fail_run("golden pair line does not hold three pairs");
            for (k = 0; k < 6; k = k + 2) begin
              exp_addr_q.push_back(w[k]);
              exp_data_q.push_back(w[k+1]);
            end
          end
          default: begin
            fail_run("golden file holds an unknown operation");
          end
        endcase
      end
    end
    $fclose(fd);
  endtask

  // reset, every operation, frame waits and a reconfiguration margin each
  function automatic longint watchdog_limit();
    longint cycles;
    int     k;
    cycles = RESET_CYCLES + 4 * FRAME_CYCLES;
    for (k = 0; k < op_q.size(); k++) begin
      cycles = cycles + OP_CYCLES;
      if (op_q[k] == "F") cycles = cycles + longint'(arg_a_q[k]) * FRAME_CYCLES;
      if (op_q[k] == "C") cycles = cycles + RECONFIG_CYCLES;
    end
    return cycles;
  endfunction

  ////////////////////////////////////////
  // bus and wait tasks
  ////////////////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_74a);
    #1;
  endtask

  task automatic wait_for_lock();
    do begin
      @(posedge clk_74a);
    end while (!pll_locked);
    #1;
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    next_cycle();
    bridge_wr      = 1'b0;
  endtask

  // read data is registered on the edge after bridge_rd
  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    next_cycle();
    bridge_rd   = 1'b0;
    data        = bridge_rd_data;
  endtask

  task automatic check_reconfig(input int count);
    int k;
    while (!uut.reconfig_pause) next_cycle();
    while (uut.reconfig_pause) next_cycle();
    check(got_addr_q.size(), count, "number of pll writes");
    for (k = 0; k < count; k++) begin
      check(got_addr_q[k], exp_addr_q[pair_ptr+k], $sformatf("pll address of pair %0d", k));
      check(got_data_q[k], exp_data_q[pair_ptr+k], $sformatf("pll data of pair %0d", k));
    end
    pair_ptr = pair_ptr + count;
    got_addr_q.delete();
    got_data_q.delete();
    wait_for_lock();
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = vs_count + n;
    while (vs_count < target) next_cycle();
  endtask

  task automatic run_op(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] data;
    case (op)
      "W": bridge_write(a, b);
      "R": begin
        bridge_read(a, data);
        check(data, b, $sformatf("read of address %h", a));
      end
      "N": begin
        bridge_read(a, data);
        check(data, vs_count & 32'hffff, "frame counter against vs pulses seen");
      end
      "C": check_reconfig(int'(a));
      "F": wait_frames(int'(a));
      default: fail_run("golden file holds an unknown operation");
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    int i;
    reset_n         = 1'b0;
    bridge_addr     = 32'd0;
    bridge_rd       = 1'b0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = 32'd0;
    pll_locked      = 1'b0;
    cfg_waitrequest = 1'b0;
    load_golden();
    limit_cycles = watchdog_limit();
    repeat (RESET_CYCLES) @(posedge clk_74a);
    #1;
    reset_n = 1'b1;
    wait_for_lock();
    for (i = 0; i < op_q.size(); i++) begin
      run_op(op_q[i], arg_a_q[i], arg_b_q[i]);
    end
    check(frames_checked != 0, 1'b1, "no pause-free frame was measured");
    check(pair_ptr, exp_addr_q.size(), "golden pairs left unused");
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_74a);
    fail_run($sformatf("timeout: run did not finish within %0d clock cycles", limit_cycles));
  end

endmodule

//--- bench/core_golden.txt
# op and hex fields: W addr data, R addr expected, N frame-counter addr, F frames
# C pair-count waits for a reconfiguration, P lines hold its addr/data pairs
R fa000000 00000011
R f3000000 00000001
R 12345678 00000000
R fa000004 00000000
W f3000000 00000002
C 9
P 00 00000000 04 00026f6e 03 00020605
P 05 00020807 05 00061716 05 00085a5a
P 05 000c5a5a 08 00000002 02 00000000
R fa000000 00000021
R f3000000 00000002
F 2
N fb000000
W f3000000 00000003
C 9
P 00 00000000 04 00024746 03 00000505
P 05 00000505 05 00040f0f 05 00083c3c
P 05 000c3c3c 08 00000003 02 00000000
R fa000000 00000031
W f3000000 00000004
C 9
P 00 00000000 04 00004040 03 00020605
P 05 00020504 05 00060e0d 05 00083636
P 05 000c3636 08 00000003 02 00000000
R fa000000 00000001
R f3000000 00000000
F 1
N fb000000

//--- verilog.f
verilog/core_video_pkg.sv
verilog/bridge_regs.sv
verilog/pll_reconfig_seq.sv
verilog/video_timing_gen.sv
verilog/core_top.sv
bench/core_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the core_top testbench with verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal \
  -f verilog.f \
  --top-module core_top_tb \
  -o core_top_tb

# the pipe returns the status of tee, the log search decides the result
./obj_dir/core_top_tb | tee "$LOG"

if grep -qF '*** PASSED ***' "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi
